//--- source/dr_latch_pkg.sv
package dr_latch_pkg;

    // queue geometry
    localparam int Q_LENGTH = 8;
    // slot index width
    localparam int PTR_W = 3;
    // counts 0..Q_LENGTH inclusive, so one bit wider than a pointer
    localparam int CNT_W = 4;

    // branch predictor alias tag
    localparam int ALIAS_W = 7;

    // modifiable part of an entry
    // squash may rewrite this after the entry is stored
    typedef struct packed {
        // cleared by a matching squash
        logic               valid;
        // alias the uop was fetched under
        logic [ALIAS_W-1:0] bp_alias;
    } m_part_t;

    // non-modifiable part of an entry
    // reduced decode bundle, written once at push
    typedef struct packed {
        // fetch address of the uop
        logic [31:0] eip;
        // operand size select
        logic [1:0]  opsize;
        // gpr sources
        logic [2:0]  reg_addr1;
        logic [2:0]  reg_addr2;
        // segment register source
        logic [2:0]  seg_addr1;
        // alu function code
        logic [4:0]  aluk;
        // control transfer flag
        logic        is_br;
        // immediate operand
        logic [31:0] imm;
        // predicted target and direction from fetch
        logic [31:0] br_pred_target;
        logic        br_pred_t_nt;
    } n_part_t;

    // one modifiable part per slot, indexed by slot number
    typedef m_part_t [Q_LENGTH-1:0] m_vec_t;

    // one bit per slot
    typedef logic [Q_LENGTH-1:0] entry_mask_t;

endpackage

//--- source/queue_nm.sv
`timescale 1ns/100ps

module queue_nm #(
    parameter type m_t = logic [7:0],
    parameter type n_t = logic [7:0]
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    // push side
    input  logic                                    wr,
    input  m_t                                      wr_m,
    input  n_t                                      wr_n,
    // pop side
    input  logic                                    rd,
    // synchronous flush
    input  logic                                    clr,
    // in-place update of the modifiable parts
    input  dr_latch_pkg::entry_mask_t               modify_mask,
    input  m_t [dr_latch_pkg::Q_LENGTH-1:0]         new_m_vec,
    output logic                                    full,
    output logic                                    empty,
    output logic                                    popped,
    output m_t [dr_latch_pkg::Q_LENGTH-1:0]         old_m_vec,
    output m_t                                      head_m,
    output n_t                                      head_n
);

    import dr_latch_pkg::*;

    // modifiable storage, packed so the whole vector goes out at once
    m_t [Q_LENGTH-1:0] m_mem;
    // payload storage, only written at push
    n_t                n_mem [Q_LENGTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // qualified push and pop
    logic do_wr;
    logic do_rd;

    // occupancy flags
    assign full  = (count == CNT_W'(Q_LENGTH));
    assign empty = (count == '0);

    // a read on an empty queue is dropped and returns nothing
    assign popped = rd && !empty;

    // clr discards any push or pop in the same cycle
    // push into a full queue cannot happen under credits, guard anyway
    assign do_wr = wr && !full && !clr;
    assign do_rd = popped && !clr;

    // head of queue straight from storage
    assign head_m    = m_mem[rd_ptr];
    assign head_n    = n_mem[rd_ptr];
    assign old_m_vec = m_mem;

    // pointers and count
    always_ff @(posedge clk) begin
        if (!rst_n || clr) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                // wrap at the last slot
                if (wr_ptr == PTR_W'(Q_LENGTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_rd) begin
                if (rd_ptr == PTR_W'(Q_LENGTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // push and pop together leave count alone
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // modifiable storage
    always_ff @(posedge clk) begin
        // squash update first
        for (int i = 0; i < Q_LENGTH; i++) begin
            if (modify_mask[i]) begin
                m_mem[i] <= new_m_vec[i];
            end
        end
        // incoming entry wins over a stale mask on its slot
        if (do_wr) begin
            m_mem[wr_ptr] <= wr_m;
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            n_mem[wr_ptr] <= wr_n;
        end
    end

endmodule

//--- source/squash_unit.sv
`timescale 1ns/100ps

module squash_unit (
    // squash request, one cycle
    input  logic                              squash,
    input  logic [dr_latch_pkg::ALIAS_W-1:0]  squash_alias,
    // current modifiable parts of all slots
    input  dr_latch_pkg::m_vec_t              old_m_vec,
    // alias of the uop decode is pushing
    input  logic [dr_latch_pkg::ALIAS_W-1:0]  dec_alias,
    output dr_latch_pkg::entry_mask_t         modify_mask,
    output dr_latch_pkg::m_vec_t              new_m_vec,
    output dr_latch_pkg::m_part_t             wr_m
);

    import dr_latch_pkg::*;

    // incoming uop hit by the same squash
    logic wr_hit;

    // per-slot alias compare
    // occupancy is not checked, empty slots get rewritten on push
    always_comb begin
        for (int i = 0; i < Q_LENGTH; i++) begin
            modify_mask[i] = squash && (old_m_vec[i].bp_alias == squash_alias);
            // alias kept, only valid drops
            new_m_vec[i].bp_alias = old_m_vec[i].bp_alias;
            new_m_vec[i].valid    = 1'b0;
        end
    end

    // same rule for the entry being written this cycle
    assign wr_hit = squash && (dec_alias == squash_alias);

    // new entry is valid unless squashed on arrival
    assign wr_m.valid    = !wr_hit;
    assign wr_m.bp_alias = dec_alias;

endmodule

//--- source/credit_gate.sv
`timescale 1ns/100ps

module credit_gate (
    input  logic clk,
    input  logic rst_n,
    // flush, reloads all credits
    input  logic clr,
    // decode wants to push this cycle
    input  logic dec_req,
    // queue released an entry
    input  logic popped,
    // push into the queue
    output logic wr,
    // decode must hold its uop
    output logic dec_stall
);

    import dr_latch_pkg::*;

    // free slots as seen from decode
    logic [CNT_W-1:0] credits;
    logic             has_credit;

    assign has_credit = (credits != '0);

    // request goes through only with a credit in hand
    assign wr        = dec_req && has_credit;
    // stall only matters while a request is pending
    assign dec_stall = dec_req && !has_credit;

    // credit counter
    always_ff @(posedge clk) begin
        if (!rst_n || clr) begin
            // one credit per queue slot
            credits <= CNT_W'(Q_LENGTH);
        end else begin
            // spend on push, return on pop
            case ({wr, popped})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                // both or neither, net zero
                default: credits <= credits;
            endcase
        end
    end

endmodule

//--- source/d_rrag_latch_top.sv
`timescale 1ns/100ps

module d_rrag_latch_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              clr,
    // decode side
    input  logic                              dec_req,
    input  dr_latch_pkg::n_part_t             dec_uop,
    input  logic [dr_latch_pkg::ALIAS_W-1:0]  dec_alias,
    output logic                              dec_stall,
    // branch squash
    input  logic                              squash,
    input  logic [dr_latch_pkg::ALIAS_W-1:0]  squash_alias,
    // rrag side
    input  logic                              rd,
    output logic                              empty,
    output dr_latch_pkg::m_part_t             head_m,
    output dr_latch_pkg::n_part_t             head_n
);

    import dr_latch_pkg::*;

    // credit gate to queue
    logic        q_wr;
    // queue back to credit gate
    logic        q_popped;
    // watched by the checker only
    logic        q_full;

    // squash path
    entry_mask_t modify_mask;
    m_vec_t      old_m_vec;
    m_vec_t      new_m_vec;
    m_part_t     wr_m;

    // decode throttle
    credit_gate credit_gate_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .clr       (clr),
        .dec_req   (dec_req),
        .popped    (q_popped),
        .wr        (q_wr),
        .dec_stall (dec_stall)
    );

    // alias match over stored and incoming entries
    squash_unit squash_unit_i (
        .squash       (squash),
        .squash_alias (squash_alias),
        .old_m_vec    (old_m_vec),
        .dec_alias    (dec_alias),
        .modify_mask  (modify_mask),
        .new_m_vec    (new_m_vec),
        .wr_m         (wr_m)
    );

    // latch storage
    queue_nm #(
        .m_t (m_part_t),
        .n_t (n_part_t)
    ) queue_nm_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr          (q_wr),
        .wr_m        (wr_m),
        .wr_n        (dec_uop),
        .rd          (rd),
        .clr         (clr),
        .modify_mask (modify_mask),
        .new_m_vec   (new_m_vec),
        .full        (q_full),
        .empty       (empty),
        .popped      (q_popped),
        .old_m_vec   (old_m_vec),
        .head_m      (head_m),
        .head_n      (head_n)
    );

endmodule

//--- sim/d_rrag_latch_checker.sv
`timescale 1ns/100ps

module d_rrag_latch_checker (
    input logic clk,
    input logic rst_n,
    // flush empties the queue
    input logic clr,
    // credit gate push and stall
    input logic wr,
    input logic dec_stall,
    // queue status
    input logic full,
    input logic popped,
    input logic empty
);

    import dr_latch_pkg::*;

    // goes high with the first push after reset
    logic             seen_wr;
    // entries held, counted from push and pop events
    logic [CNT_W-1:0] occ;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seen_wr <= 1'b0;
        end else if (wr) begin
            seen_wr <= 1'b1;
        end
    end

    // occupancy seen from outside the queue
    always_ff @(posedge clk) begin
        if (!rst_n || clr) begin
            occ <= '0;
        end else begin
            case ({wr, popped})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
        end
    end

    // credits keep the queue from overflowing
    a_no_wr_when_full: assert property (@(posedge clk) disable iff (!rst_n) wr |-> !full)
        else $error("push issued while the queue is full");

    // pop only from an occupied queue
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) popped |-> (occ != '0)
    ) else $error("pop reported while no entry is held");

    // stall only with the queue really full and no push
    a_stall_excludes_wr: assert property (
        @(posedge clk) disable iff (!rst_n) dec_stall |-> (full && !wr)
    ) else $error("stall without a full queue or together with a push");

    // queue stays empty out of reset until something is pushed
    a_empty_after_reset: assert property (@(posedge clk) disable iff (!rst_n) !seen_wr |-> empty)
        else $error("queue not empty before the first push");

endmodule

// credit gate and queue nets as wired in the top
bind d_rrag_latch_top d_rrag_latch_checker checker_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .clr       (clr),
    .wr        (q_wr),
    .dec_stall (dec_stall),
    .full      (q_full),
    .popped    (q_popped),
    .empty     (empty)
);

//--- sim/d_rrag_latch_tb.sv
`timescale 1ns/100ps

module d_rrag_latch_tb;

    import dr_latch_pkg::*;

    localparam int RAND_CYCLES    = 400;
    // reset, order, back-pressure, squash, squash on write, clear, random, tail
    localparam int TEST_CYCLES    = 8 + 40 + 30 + 30 + 25 + 40 + RAND_CYCLES + 20;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 100;

    // one model queue slot
    typedef struct packed {
        m_part_t m;
        n_part_t n;
    } entry_t;

    logic               clk;
    logic               rst_n;
    logic               clr;
    logic               dec_req;
    n_part_t            dec_uop;
    logic [ALIAS_W-1:0] dec_alias;
    logic               dec_stall;
    logic               squash;
    logic [ALIAS_W-1:0] squash_alias;
    logic               rd;
    logic               empty;
    m_part_t            head_m;
    n_part_t            head_n;

    // reference state
    entry_t      model_q[$];
    int          model_credits;
    logic [31:0] lcg_state;
    int          err_value;
    int          err_other;
    int          cycle_cnt;

    d_rrag_latch_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .clr          (clr),
        .dec_req      (dec_req),
        .dec_uop      (dec_uop),
        .dec_alias    (dec_alias),
        .dec_stall    (dec_stall),
        .squash       (squash),
        .squash_alias (squash_alias),
        .rd           (rd),
        .empty        (empty),
        .head_m       (head_m),
        .head_n       (head_n)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [ALIAS_W-1:0] rand_alias();
        logic [31:0] r;
        r = lcg_next();
        return r[22:16];
    endfunction

    function automatic n_part_t rand_uop();
        n_part_t     u;
        logic [31:0] r;
        r                = lcg_next();
        u.eip            = lcg_next();
        u.imm            = lcg_next();
        u.br_pred_target = lcg_next();
        u.opsize         = r[1:0];
        u.reg_addr1      = r[4:2];
        u.reg_addr2      = r[7:5];
        u.seg_addr1      = r[10:8];
        u.aluk           = r[15:11];
        u.is_br          = r[16];
        u.br_pred_t_nt   = r[17];
        return u;
    endfunction

    // one clock edge of the latch in the order clr, squash, gated write, pop
    function automatic void model_step(input logic c, input logic req, input n_part_t uop,
                                       input logic [ALIAS_W-1:0] a, input logic sq,
                                       input logic [ALIAS_W-1:0] sqa, input logic r);
        entry_t e;
        logic   do_pop;
        logic   do_wr;
        if (c) begin
            model_q.delete();
            model_credits = Q_LENGTH;
            return;
        end
        // pop decision uses occupancy before the edge
        do_pop = r && (model_q.size() != 0);
        do_wr  = req && (model_credits != 0);
        for (int i = 0; i < model_q.size(); i++) begin
            if (sq && (model_q[i].m.bp_alias == sqa)) begin
                e            = model_q[i];
                e.m.valid    = 1'b0;
                model_q[i]   = e;
            end
        end
        if (do_wr) begin
            e.m.valid    = !(sq && (a == sqa));
            e.m.bp_alias = a;
            e.n          = uop;
            model_q.push_back(e);
            model_credits--;
        end
        if (do_pop) begin
            void'(model_q.pop_front());
            model_credits++;
        end
    endfunction

    task automatic check_m(input string name, input m_part_t got, input m_part_t exp);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_n(input string name, input n_part_t got, input n_part_t exp);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_cnt(input string name, input logic [CNT_W-1:0] got,
                             input logic [CNT_W-1:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    // compare against the model state before each edge, then advance it
    always @(posedge clk) begin
        if (rst_n) begin
            check_bit("empty", empty, model_q.size() == 0);
            check_bit("dec_stall", dec_stall, dec_req && (model_credits == 0));
            if (model_q.size() != 0) begin
                check_m("head_m", head_m, model_q[0].m);
                check_n("head_n", head_n, model_q[0].n);
            end
        end
        model_step(!rst_n || clr, dec_req, dec_uop, dec_alias, squash, squash_alias, rd);
    end

    task automatic print_counts();
        $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            err_other++;
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_counts();
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // drive all inputs at the falling edge, report acceptance at the next rising edge
    task automatic drive_cycle(input logic req, input n_part_t uop, input logic [ALIAS_W-1:0] a,
                               input logic r, input logic sq, input logic [ALIAS_W-1:0] sqa,
                               input logic c, output logic acc);
        @(negedge clk);
        dec_req      = req;
        dec_uop      = uop;
        dec_alias    = a;
        rd           = r;
        squash       = sq;
        squash_alias = sqa;
        clr          = c;
        @(posedge clk);
        acc = req && !dec_stall && !c;
    endtask

    // hold one uop until the credit handshake takes it
    task automatic push_one(input logic [ALIAS_W-1:0] a, input logic r);
        n_part_t u;
        logic    acc;
        u   = rand_uop();
        acc = 1'b0;
        while (!acc) begin
            drive_cycle(1'b1, u, a, r, 1'b0, '0, 1'b0, acc);
        end
    endtask

    task automatic drain();
        logic acc;
        logic was_empty;
        was_empty = 1'b0;
        while (!was_empty) begin
            drive_cycle(1'b0, '0, '0, 1'b1, 1'b0, '0, 1'b0, acc);
            was_empty = empty;
        end
    endtask

    task automatic flush();
        logic acc;
        drive_cycle(1'b0, '0, '0, 1'b0, 1'b0, '0, 1'b1, acc);
    endtask

    // request every cycle, read only in cycle rd_at
    task automatic count_accepts(input int cycles, input int rd_at, output int n_acc);
        n_part_t u;
        logic    acc;
        n_acc = 0;
        u     = rand_uop();
        for (int k = 0; k < cycles; k++) begin
            drive_cycle(1'b1, u, 7'h05, k == rd_at, 1'b0, '0, 1'b0, acc);
            if (acc) begin
                n_acc++;
                u = rand_uop();
            end
        end
    endtask

    task automatic test_order();
        for (int i = 0; i < 6; i++) begin
            push_one(rand_alias(), 1'b0);
        end
        // pushes overlapping pops
        for (int i = 0; i < 10; i++) begin
            push_one(rand_alias(), 1'b1);
        end
        drain();
    endtask

    task automatic test_backpressure();
        int n;
        flush();
        count_accepts(12, -1, n);
        check_cnt("accepted_until_stall", CNT_W'(n), CNT_W'(Q_LENGTH));
        // one pop frees exactly one credit
        count_accepts(5, 0, n);
        check_cnt("accepted_after_read", CNT_W'(n), CNT_W'(1));
        drain();
    endtask

    task automatic test_squash();
        logic acc;
        for (int i = 0; i < Q_LENGTH; i++) begin
            push_one((i % 2 == 1) ? 7'h15 : 7'h2a, 1'b0);
        end
        drive_cycle(1'b0, '0, '0, 1'b0, 1'b1, 7'h2a, 1'b0, acc);
        // alias not in the queue
        drive_cycle(1'b0, '0, '0, 1'b0, 1'b1, 7'h33, 1'b0, acc);
        drain();
    endtask

    task automatic test_squash_on_write();
        logic acc;
        push_one(7'h11, 1'b0);
        push_one(7'h11, 1'b0);
        drive_cycle(1'b1, rand_uop(), 7'h11, 1'b0, 1'b1, 7'h11, 1'b0, acc);
        check_bit("accept_on_squash", acc, 1'b1);
        drive_cycle(1'b1, rand_uop(), 7'h12, 1'b0, 1'b1, 7'h11, 1'b0, acc);
        drain();
    endtask

    task automatic test_clear();
        logic acc;
        int   n;
        for (int i = 0; i < 5; i++) begin
            push_one(rand_alias(), 1'b0);
        end
        // clr with a push and a pop in the same cycle
        drive_cycle(1'b1, rand_uop(), 7'h03, 1'b1, 1'b0, '0, 1'b1, acc);
        for (int i = 0; i < 3; i++) begin
            drive_cycle(1'b0, '0, '0, 1'b1, 1'b0, '0, 1'b0, acc);
            check_bit("empty_after_clr", empty, 1'b1);
        end
        count_accepts(10, -1, n);
        check_cnt("credits_after_clr", CNT_W'(n), CNT_W'(Q_LENGTH));
        drain();
    endtask

    task automatic test_random();
        logic               pending;
        n_part_t            pend_uop;
        logic [ALIAS_W-1:0] pend_alias;
        logic [31:0]        r;
        logic               acc;
        pending    = 1'b0;
        pend_uop   = '0;
        pend_alias = '0;
        for (int k = 0; k < RAND_CYCLES; k++) begin
            r = lcg_next();
            if (!pending && r[20]) begin
                pending    = 1'b1;
                pend_uop   = rand_uop();
                // small alias set so squashes hit
                pend_alias = 7'h40 | {5'd0, r[19:18]};
            end
            drive_cycle(pending, pend_uop, pend_alias, r[22], r[26:24] == 3'd0,
                        7'h40 | {5'd0, r[29:28]}, r[15:10] == 6'd0, acc);
            if (acc || (r[15:10] == 6'd0)) begin
                pending = 1'b0;
            end
        end
        drain();
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        clr           = 1'b0;
        dec_req       = 1'b0;
        dec_uop       = '0;
        dec_alias     = '0;
        squash        = 1'b0;
        squash_alias  = '0;
        rd            = 1'b0;
        lcg_state     = 32'd59355;
        model_credits = Q_LENGTH;
        err_value     = 0;
        err_other     = 0;
        cycle_cnt     = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        test_order();
        test_backpressure();
        test_squash();
        test_squash_on_write();
        test_clear();
        test_random();
        flush();
        print_counts();
        if (err_value + err_other == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- d_rrag_latch.f
source/dr_latch_pkg.sv
source/queue_nm.sv
source/squash_unit.sv
source/credit_gate.sv
source/d_rrag_latch_top.sv
sim/d_rrag_latch_checker.sv
sim/d_rrag_latch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the decode to rrag latch testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f d_rrag_latch.f --top-module d_rrag_latch_tb -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0
